// ==== Makefile ====
.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing -Wno-fatal --top-module dinoGameTb -f build.f -Mdir obj_dir

run: compile
	@out="$$(./obj_dir/VdinoGameTb)"; \
	echo "$$out"; \
	echo "$$out" | grep -q "ALL TESTS PASSED"

clean:
	rm -rf obj_dir

// ==== bench/clockGen.sv ====
`timescale 1ns/1ps
`default_nettype none

module clockGen #(
  parameter real periodNs = 4.0
) (
  output logic clk
);

  initial begin
    clk = 1'b0;
    forever #(periodNs / 2.0) clk = ~clk;
  end

endmodule

`default_nettype wire

// ==== bench/dinoGameTb.sv ====
`timescale 1ns/1ps
`default_nettype none

module dinoGameTb;

  localparam int tickCycles = 8;
  localparam int holdCycles = 3;
  localparam int winScore   = 2;

  logic clk;
  logic nRst;
  logic button;
  logic restart;
  logic drawDone;
  dinoPkg::gameState_t gameState;
  logic [7:0] dinoY;
  logic [7:0] dinoV;
  logic       dinoMoved;
  logic       jumpGood;
  logic [7:0] cactusX;
  logic [7:0] score;

  int errors = 0;
  int timeouts = 0;
  int jumpsSeen = 0;
  int jumpChanges = 0;
  bit jumpAllowed = 1'b0;
  logic [31:0] rngButton = 32'h9775_88c4;
  logic [31:0] rngDraw;

  clockGen clockGen_inst (.clk(clk));

  dinoGameTop #(
    .tickCycles(tickCycles),
    .holdCycles(holdCycles),
    .winScore(winScore)
  ) dinoGameTop_inst (
    .clk(clk),
    .nRst(nRst),
    .button(button),
    .restart(restart),
    .drawDone(drawDone),
    .gameState(gameState),
    .dinoY(dinoY),
    .dinoV(dinoV),
    .dinoMoved(dinoMoved),
    .jumpGood(jumpGood),
    .cactusX(cactusX),
    .score(score)
  );

  // ==================================================
  // reference model and helpers
  // ==================================================
  function automatic logic [31:0] xorshift(input logic [31:0] x);
    logic [31:0] r;
    r = x ^ (x << 13);
    r = r ^ (r >> 17);
    r = r ^ (r << 5);
    return r;
  endfunction

  // one gravity step where a grounded dino stays put
  function automatic logic [15:0] nextJump(input logic [7:0] y, input logic [7:0] v);
    logic [7:0] ny;
    logic [7:0] nv;
    if (y == dinoPkg::floorY) begin
      return {y, 8'd0};
    end
    ny = y + v;
    nv = (ny == dinoPkg::floorY) ? 8'd0 : v - 8'd1;
    return {ny, nv};
  endfunction

  // distinct heights from launch until landing
  function automatic int flightChanges();
    logic [7:0] y;
    logic [7:0] v;
    logic [7:0] oldY;
    int n;
    y = dinoPkg::floorY + dinoPkg::launchStep;
    v = dinoPkg::launchV;
    n = 1;
    while (y != dinoPkg::floorY && n < 100) begin
      oldY = y;
      {y, v} = nextJump(y, v);
      if (y != oldY) n++;
    end
    return n;
  endfunction

  task automatic checkState(input string name, input dinoPkg::gameState_t exp,
                            input dinoPkg::gameState_t act);
    if (exp !== act) begin
      $display("CHECK FAILED %s: expected %s, actual %s", name, exp.name(), act.name());
      errors++;
    end
  endtask

  task automatic checkByte(input string name, input logic [7:0] exp, input logic [7:0] act);
    if (exp !== act) begin
      $display("CHECK FAILED %s: expected %0d, actual %0d", name, exp, act);
      errors++;
    end
  endtask

  task automatic complain(input string what);
    $display("%s", what);
    errors++;
  endtask

  task automatic finishRun();
    $display("errors: %0d, timeouts: %0d", errors, timeouts);
    if (errors == 0 && timeouts == 0) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  endtask

  task automatic timedOut(input string what);
    $display("timeout while waiting for %s", what);
    timeouts++;
    finishRun();
  endtask

  task automatic waitState(input dinoPkg::gameState_t target, input int limit);
    int n;
    for (n = 0; n < limit && gameState != target; n++) @(negedge clk);
    if (gameState != target) timedOut({"state ", target.name()});
  endtask

  task automatic waitCactus(input logic [7:0] x, input int limit);
    int n;
    for (n = 0; n < limit && cactusX != x; n++) @(negedge clk);
    if (cactusX != x) timedOut("cactus position");
  endtask

  // hold the button from the floor and follow the flight to the ground
  task automatic jumpAndLand();
    int n;
    int seen;
    int base;
    seen = jumpsSeen;
    base = jumpChanges;
    jumpAllowed = 1'b1;
    button = 1'b1;
    for (n = 0; n < 10 && jumpsSeen == seen; n++) @(negedge clk);
    button = 1'b0;
    jumpAllowed = 1'b0;
    if (jumpsSeen == seen) timedOut("jumpGood");
    checkByte("hold before jump", 8'(holdCycles), 8'(n));
    for (n = 0; n < 400 && dinoY == dinoPkg::floorY; n++) @(negedge clk);
    for (n = 0; n < 400 && dinoY != dinoPkg::floorY; n++) @(negedge clk);
    if (dinoY != dinoPkg::floorY) timedOut("landing");
    @(negedge clk);
    checkByte("flight steps", 8'(flightChanges()), 8'(jumpChanges - base));
    checkByte("speed after landing", 8'd0, dinoV);
  endtask

  // ==================================================
  // compare process sampling just before each edge
  // ==================================================
  logic [7:0] prevY, prevX, prevScore, modelY, modelV, oldY, expY;
  logic prevMoved, prevDraw, prevJump, armed;
  dinoPkg::gameState_t prevState;

  always @(posedge clk) begin
    if (!nRst) begin
      armed = 1'b0;
    end else if (!armed) begin
      armed = 1'b1;
      modelY = dinoPkg::floorY;
      modelV = 8'd0;
    end else begin
      if (jumpGood) begin
        if (!jumpAllowed) complain("jumpGood rose without a deliberate hold from the floor");
        jumpsSeen++;
      end
      if (dinoY != prevY) begin
        if (!dinoMoved) complain("dinoMoved did not rise after a height change");
        if (prevState == dinoPkg::RUN) begin
          if (prevJump) begin
            modelY = modelY + dinoPkg::launchStep;
            modelV = dinoPkg::launchV;
          end else begin
            oldY = modelY;
            for (int k = 0; k < 4 && modelY == oldY; k++) begin
              {modelY, modelV} = nextJump(modelY, modelV);
            end
          end
          checkByte("jump height", modelY, dinoY);
          checkByte("jump speed", modelV, dinoV);
          jumpChanges++;
        end else begin
          expY = (prevState == dinoPkg::IDLE) ? dinoPkg::floorY : 8'd0;
          checkByte("height outside RUN", expY, dinoY);
          modelY = expY;
          modelV = 8'd0;
        end
      end
      if (prevMoved && !dinoMoved && !(prevDraw && dinoY == prevY))
        complain("dinoMoved fell without drawDone or while the height changed");
      if (prevMoved && prevDraw && dinoY == prevY && dinoMoved)
        complain("dinoMoved stayed high after drawDone with a steady height");
      if (!prevMoved && dinoMoved && dinoY == prevY)
        complain("dinoMoved rose without a height change");
      if (cactusX != prevX || score != prevScore) begin
        if (prevState == dinoPkg::RUN) begin
          checkByte("cactus step", (prevX == 8'd0) ? dinoPkg::screenRight : prevX - 8'd1, cactusX);
          checkByte("score", (prevX == 8'd0) ? prevScore + 8'd1 : prevScore, score);
        end else if (prevState == dinoPkg::IDLE) begin
          checkByte("cactus in IDLE", dinoPkg::screenRight, cactusX);
          checkByte("score in IDLE", 8'd0, score);
        end else begin
          complain("cactus or score moved while the game was frozen");
        end
      end
    end
    prevY = dinoY;  // values of the cycle that just ended
    prevX = cactusX;
    prevScore = score;
    prevMoved = dinoMoved;
    prevDraw = drawDone;
    prevJump = jumpGood;
    prevState = gameState;
  end

  // renderer stand-in giving drawDone at random gaps
  int drawGap = 0;
  always @(negedge clk) begin
    if (!armed) begin
      drawDone = 1'b0;
    end else if (drawGap == 0) begin
      drawDone = 1'b1;
      rngDraw = xorshift(rngDraw);
      drawGap = 2 + int'(rngDraw % 12);
    end else begin
      drawDone = 1'b0;
      drawGap--;
    end
  end

  // ==================================================
  // stimulus
  // ==================================================
  initial begin
    int len;
    nRst = 1'b0;
    button = 1'b0;
    restart = 1'b0;
    drawDone = 1'b0;
    rngDraw = xorshift(rngButton);
    repeat (16) @(negedge clk);
    nRst = 1'b1;
    @(negedge clk);

    checkState("state after reset", dinoPkg::IDLE, gameState);
    checkByte("height after reset", dinoPkg::floorY, dinoY);
    checkByte("speed after reset", 8'd0, dinoV);
    checkByte("cactus after reset", dinoPkg::screenRight, cactusX);
    checkByte("score after reset", 8'd0, score);
    checkByte("redraw after reset", 8'd0, 8'(dinoMoved));

    button = 1'b1;  // start the game
    @(negedge clk);
    button = 1'b0;
    waitState(dinoPkg::RUN, 10);

    // short presses are filtered out
    for (int i = 0; i < 10; i++) begin
      rngButton = xorshift(rngButton);
      len = 1 + int'(rngButton % (holdCycles - 1));
      button = 1'b1;
      repeat (len) @(negedge clk);
      button = 1'b0;
      rngButton = xorshift(rngButton);
      repeat (1 + int'(rngButton % 4)) @(negedge clk);
      checkByte("height after short press", dinoPkg::floorY, dinoY);
    end

    // a full jump with a hold in mid flight
    fork
      jumpAndLand();
      begin
        repeat (40) @(negedge clk);
        button = 1'b1;
        repeat (holdCycles + 2) @(negedge clk);
        button = 1'b0;
      end
    join

    // with no more jumps the cactus runs into the dino
    waitState(dinoPkg::OVER, 2000);
    checkByte("cactus at crash", dinoPkg::dinoX + dinoPkg::dinoWidth - 8'd1, cactusX);
    repeat (4) @(negedge clk);
    checkByte("hidden height in OVER", 8'd0, dinoY);
    checkByte("cactus held in OVER", dinoPkg::dinoX + dinoPkg::dinoWidth - 8'd1, cactusX);
    checkByte("score held in OVER", 8'd0, score);
    restart = 1'b1;
    @(negedge clk);
    restart = 1'b0;
    waitState(dinoPkg::IDLE, 10);
    @(negedge clk);
    checkByte("height after restart", dinoPkg::floorY, dinoY);
    checkByte("cactus after restart", dinoPkg::screenRight, cactusX);
    checkByte("score after restart", 8'd0, score);

    // second run clears every cactus
    button = 1'b1;
    @(negedge clk);
    button = 1'b0;
    waitState(dinoPkg::RUN, 10);
    for (int i = 0; i < winScore; i++) begin
      waitCactus(dinoPkg::dinoX + dinoPkg::dinoWidth + 8'd5, 2000);
      jumpAndLand();
    end
    waitState(dinoPkg::WIN, 2000);
    repeat (4) @(negedge clk);
    checkState("state at the end of run two", dinoPkg::WIN, gameState);
    checkByte("score in WIN", 8'(winScore), score);
    checkByte("cactus held in WIN", dinoPkg::screenRight, cactusX);
    checkByte("hidden height in WIN", 8'd0, dinoY);
    restart = 1'b1;
    @(negedge clk);
    restart = 1'b0;
    waitState(dinoPkg::IDLE, 10);
    @(negedge clk);
    checkByte("height after second restart", dinoPkg::floorY, dinoY);
    checkByte("speed after second restart", 8'd0, dinoV);
    checkByte("score after second restart", 8'd0, score);
    repeat (4) @(negedge clk);
    finishRun();
  end

endmodule

`default_nettype wire

// ==== build.f ====
hw/dinoPkg.sv
hw/frameTimer.sv
hw/dinoJump.sv
hw/obstacleScroll.sv
hw/gameStateCtrl.sv
hw/dinoGameTop.sv
bench/clockGen.sv
bench/dinoGameTb.sv

// ==== hw/dinoGameTop.sv ====
`timescale 1ns/1ps
`default_nettype none

module dinoGameTop #(
  parameter int tickCycles = 400000,  // clock cycles per physics step
  parameter int holdCycles = 300000,  // button hold before a jump
  parameter int winScore   = 10
) (
  input  wire                 clk,
  input  wire                 nRst,
  input  wire                 button,
  input  wire                 restart,
  input  wire                 drawDone,
  output dinoPkg::gameState_t gameState,
  output logic [7:0]          dinoY,
  output logic [7:0]          dinoV,
  output logic                dinoMoved,
  output logic                jumpGood,
  output logic [7:0]          cactusX,
  output logic [7:0]          score
);

  logic tick;  // shared step for dino and cactus

  gameStateCtrl #(.winScore(winScore)) gameStateCtrl_inst (
    .clk(clk),
    .nRst(nRst),
    .button(button),
    .restart(restart),
    .dinoY(dinoY),
    .cactusX(cactusX),
    .score(score),
    .gameState(gameState)
  );

  frameTimer #(.tickCycles(tickCycles)) frameTimer_inst (
    .clk(clk),
    .nRst(nRst),
    .gameState(gameState),
    .tick(tick)
  );

  dinoJump #(.holdCycles(holdCycles)) dinoJump_inst (
    .clk(clk),
    .nRst(nRst),
    .button(button),
    .gameState(gameState),
    .tick(tick),
    .drawDone(drawDone),
    .dinoY(dinoY),
    .dinoV(dinoV),
    .jumpGood(jumpGood),
    .dinoMoved(dinoMoved)
  );

  obstacleScroll obstacleScroll_inst (
    .clk(clk),
    .nRst(nRst),
    .gameState(gameState),
    .tick(tick),
    .cactusX(cactusX),
    .score(score)
  );

endmodule

`default_nettype wire

// ==== hw/dinoJump.sv ====
`timescale 1ns/1ps
`default_nettype none

module dinoJump #(
  parameter int holdCycles = 300000
) (
  input  wire                     clk,
  input  wire                     nRst,
  input  wire                     button,
  input  var dinoPkg::gameState_t gameState,
  input  wire                     tick,
  input  wire                     drawDone,
  output logic [7:0]              dinoY,
  output logic [7:0]              dinoV,
  output logic                    jumpGood,
  output logic                    dinoMoved
);

  localparam int holdW = (holdCycles > 1) ? $clog2(holdCycles) : 1;

  logic [holdW-1:0] holdCnt;
  logic [holdW-1:0] holdCntNext;
  logic             launch;
  logic             onFloor;
  logic [7:0]       fallY;
  logic [7:0]       dinoYNext;
  logic [7:0]       dinoVNext;
  logic             movedNext;

  assign onFloor = (dinoY == dinoPkg::floorY);
  assign fallY   = dinoY + dinoV;  // dinoV is two's complement

  // ================================================
  // button hold filter
  // ================================================
  always_comb begin
    holdCntNext = '0;
    launch      = 1'b0;
    if (gameState == dinoPkg::RUN && button) begin
      if (holdCnt == holdW'(holdCycles - 1)) begin
        launch = 1'b1;  // count restarts from zero
      end else begin
        holdCntNext = holdCnt + 1'b1;
      end
    end
  end

  assign jumpGood = launch && onFloor;  // only a grounded dino may jump

  // ================================================
  // height and vertical speed
  // ================================================
  always_comb begin
    dinoYNext = dinoY;
    dinoVNext = dinoV;
    case (gameState)
      dinoPkg::IDLE: begin
        dinoYNext = dinoPkg::floorY;
        dinoVNext = 8'd0;
      end
      dinoPkg::RUN: begin
        if (jumpGood) begin
          dinoYNext = dinoY + dinoPkg::launchStep;
          dinoVNext = dinoPkg::launchV;
        end else if (tick && !onFloor) begin
          dinoYNext = fallY;
          // landing stops the fall, otherwise gravity pulls one step
          dinoVNext = (fallY == dinoPkg::floorY) ? 8'd0 : dinoV - 8'd1;
        end
      end
      default: begin  // WIN and OVER hide the dino
        dinoYNext = 8'd0;
        dinoVNext = 8'd0;
      end
    endcase
  end

  // redraw request where a fresh move beats drawDone
  always_comb begin
    if (dinoYNext != dinoY) begin
      movedNext = 1'b1;
    end else if (drawDone) begin
      movedNext = 1'b0;
    end else begin
      movedNext = dinoMoved;
    end
  end

  always_ff @(posedge clk, negedge nRst) begin
    if (!nRst) begin
      holdCnt   <= '0;
      dinoY     <= dinoPkg::floorY;
      dinoV     <= 8'd0;
      dinoMoved <= 1'b0;
    end else begin
      holdCnt   <= holdCntNext;
      dinoY     <= dinoYNext;
      dinoV     <= dinoVNext;
      dinoMoved <= movedNext;
    end
  end

endmodule

`default_nettype wire

// ==== hw/dinoPkg.sv ====
`default_nettype none

package dinoPkg;

  // ================================================
  // game phase
  // ================================================
  typedef enum logic [1:0] {
    IDLE = 2'd0,
    RUN  = 2'd1,
    WIN  = 2'd2,
    OVER = 2'd3
  } gameState_t;

  // ================================================
  // playfield geometry
  // ================================================
  localparam logic [7:0] floorY       = 8'd101;  // dino height when standing
  localparam logic [7:0] dinoX        = 8'd16;   // left column of the dino
  localparam logic [7:0] dinoWidth    = 8'd8;
  localparam logic [7:0] cactusHeight = 8'd12;   // above the floor
  localparam logic [7:0] screenRight  = 8'd159;  // cactus spawn column

  // jump launch
  localparam logic [7:0] launchV      = 8'd10;   // starting upward speed
  localparam logic [7:0] launchStep   = 8'd11;   // extra height in the launch cycle

endpackage

`default_nettype wire

// ==== hw/frameTimer.sv ====
`timescale 1ns/1ps
`default_nettype none

module frameTimer #(
  parameter int tickCycles = 400000
) (
  input  wire                     clk,
  input  wire                     nRst,
  input  var dinoPkg::gameState_t gameState,
  output logic                    tick
);

  localparam int cntW = (tickCycles > 1) ? $clog2(tickCycles) : 1;

  logic [cntW-1:0] count;
  logic            running;

  assign running = (gameState == dinoPkg::RUN);
  assign tick    = running && (count == cntW'(tickCycles - 1));  // last cycle of the period

  always_ff @(posedge clk, negedge nRst) begin
    if (!nRst) begin
      count <= '0;
    end else if (!running || tick) begin
      count <= '0;  // parked outside RUN, wraps after a tick
    end else begin
      count <= count + 1'b1;
    end
  end

endmodule

`default_nettype wire

// ==== hw/gameStateCtrl.sv ====
`timescale 1ns/1ps
`default_nettype none

module gameStateCtrl #(
  parameter int winScore = 10
) (
  input  wire                       clk,
  input  wire                       nRst,
  input  wire                       button,
  input  wire                       restart,
  input  wire  [7:0]                dinoY,
  input  wire  [7:0]                cactusX,
  input  wire  [7:0]                score,
  output dinoPkg::gameState_t       gameState
);

  dinoPkg::gameState_t stateNext;

  logic inColumns;
  logic lowEnough;
  logic hit;
  logic won;

  // ================================================
  // hit box and win target
  // ================================================
  assign inColumns = (cactusX >= dinoPkg::dinoX) &&
                     (cactusX < 8'(dinoPkg::dinoX + dinoPkg::dinoWidth));
  assign lowEnough = (dinoY < 8'(dinoPkg::floorY + dinoPkg::cactusHeight));
  assign hit       = inColumns && lowEnough;
  assign won       = (score == 8'(winScore));

  // ================================================
  // phase FSM
  // ================================================
  always_comb begin
    stateNext = gameState;
    case (gameState)
      dinoPkg::IDLE: begin
        if (button) begin
          stateNext = dinoPkg::RUN;
        end
      end
      dinoPkg::RUN: begin
        if (hit) begin
          stateNext = dinoPkg::OVER;  // a crash outranks the score
        end else if (won) begin
          stateNext = dinoPkg::WIN;
        end
      end
      dinoPkg::WIN, dinoPkg::OVER: begin
        if (restart) begin
          stateNext = dinoPkg::IDLE;
        end
      end
      default: begin
        stateNext = dinoPkg::IDLE;
      end
    endcase
  end

  always_ff @(posedge clk, negedge nRst) begin
    if (!nRst) begin
      gameState <= dinoPkg::IDLE;
    end else begin
      gameState <= stateNext;
    end
  end

endmodule

`default_nettype wire

// ==== hw/obstacleScroll.sv ====
`timescale 1ns/1ps
`default_nettype none

module obstacleScroll (
  input  wire                     clk,
  input  wire                     nRst,
  input  var dinoPkg::gameState_t gameState,
  input  wire                     tick,
  output logic [7:0]              cactusX,
  output logic [7:0]              score
);

  logic [7:0] cactusXNext;
  logic [7:0] scoreNext;

  always_comb begin
    cactusXNext = cactusX;  // WIN and OVER freeze the field
    scoreNext   = score;
    case (gameState)
      dinoPkg::IDLE: begin
        cactusXNext = dinoPkg::screenRight;
        scoreNext   = 8'd0;
      end
      dinoPkg::RUN: begin
        if (tick) begin
          if (cactusX == 8'd0) begin
            cactusXNext = dinoPkg::screenRight;  // respawn at the right edge
            scoreNext   = score + 8'd1;          // one more cactus cleared
          end else begin
            cactusXNext = cactusX - 8'd1;
          end
        end
      end
      default: begin
        cactusXNext = cactusX;
        scoreNext   = score;
      end
    endcase
  end

  always_ff @(posedge clk, negedge nRst) begin
    if (!nRst) begin
      cactusX <= dinoPkg::screenRight;
      score   <= 8'd0;
    end else begin
      cactusX <= cactusXNext;
      score   <= scoreNext;
    end
  end

endmodule

`default_nettype wire
